// ==== cmd_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_latch (
    input  logic                  clk,
    input  logic                  local_srst,
    input  logic                  cmd_valid,
    input  proxy_pkg::proxy_cmd_t cmd,
    input  logic                  accept,
    output logic                  req,
    output proxy_pkg::proxy_cmd_t cur_cmd,
    output proxy_pkg::burst_len_t burst_len
);
    import proxy_pkg::*;

    // ------------------------------
    // Pending request
    // ------------------------------
    // Set by the host strobe, dropped once the FSM sits in idle
    always_ff @(posedge clk) begin
        if (local_srst) begin
            req <= 1'b0;
        end else if (cmd_valid) begin
            req <= 1'b1;
        end else if (accept) begin
            req <= 1'b0;
        end
    end

    // ------------------------------
    // Command capture
    // ------------------------------
    // Length of zero runs a single word
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            cur_cmd <= cmd;
            if (cmd.len == '0) begin
                burst_len <= burst_len_t'(1);
            end else begin
                burst_len <= cmd.len;
            end
        end
    end

endmodule : cmd_latch

`default_nettype wire

// ==== flist.f ====
+incdir+.
proxy_pkg.sv
cmd_latch.sv
proxy_fsm.sv
result_regs.sv
proxy_top.sv
tb_clk_gen.sv
tb_mem_model.sv
tb_checker.sv
proxy_assert.sv
tb_proxy.sv

// ==== proxy_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module proxy_assert (
    input logic                clk,
    input logic                local_srst,
    input logic                init_done,
    input proxy_pkg::mem_req_t mem_req,
    input logic                done_pulse,
    input logic                error_pulse,
    input logic                timeout_pulse
);

    // No memory traffic until init has finished
    no_req_before_init: assert property (@(posedge clk)
        (!local_srst && !init_done) |-> !mem_req.req)
        else $error("memory request issued while init_done is low");

    one_pulse_per_cycle: assert property (@(posedge clk)
        $onehot0({done_pulse, error_pulse, timeout_pulse}))
        else $error("more than one completion pulse in the same cycle");

    // Init is a single-cycle pulse, also when clear re-runs it
    init_one_cycle: assert property (@(posedge clk)
        (!local_srst && mem_req.init) |=> !mem_req.init)
        else $error("memory init held high for more than one cycle");

endmodule : proxy_assert

bind proxy_fsm proxy_assert i_proxy_assert (
    .clk           (clk),
    .local_srst    (local_srst),
    .init_done     (init_done),
    .mem_req       (mem_req),
    .done_pulse    (done_pulse),
    .error_pulse   (error_pulse),
    .timeout_pulse (timeout_pulse)
);

`default_nettype wire

// ==== proxy_cfg.svh ====
`ifndef PROXY_CFG_SVH
`define PROXY_CFG_SVH

// Memory port geometry
`define PROXY_ADDR_W 16
`define PROXY_DATA_W 32
`define PROXY_DATA_BYTES 4

// Longest burst carried by one command
`define PROXY_BURST_MAX 4

// Wait after the memory init pulse before polling rdy
`define PROXY_INIT_DEBOUNCE 8

// Acknowledge timeout, counted from the first request of a command
`define PROXY_TIMEOUT_CYCLES 64

`endif

// ==== proxy_fsm.sv ====
`timescale 1ns/1ps
`include "proxy_cfg.svh"
`default_nettype none

module proxy_fsm (
    input  logic                    clk,
    input  logic                    local_srst,
    input  logic                    req,
    input  proxy_pkg::proxy_cmd_t   cur_cmd,
    input  proxy_pkg::burst_len_t   burst_len,
    input  proxy_pkg::mem_rsp_t     mem_rsp,
    output logic                    accept,
    output logic                    init_done,
    output proxy_pkg::mem_req_t     mem_req,
    output proxy_pkg::proxy_state_e state,
    output proxy_pkg::burst_len_t   word,
    output logic                    done_pulse,
    output logic                    error_pulse,
    output logic                    timeout_pulse
);
    import proxy_pkg::*;

    // One timer serves both the debounce and the ack timeout
    localparam int TIMER_MAX = (`PROXY_TIMEOUT_CYCLES > `PROXY_INIT_DEBOUNCE) ?
                               `PROXY_TIMEOUT_CYCLES : `PROXY_INIT_DEBOUNCE;
    localparam int TIMER_W   = $clog2(TIMER_MAX + 1);
    localparam int IDX_W     = $clog2(`PROXY_BURST_MAX);

    proxy_state_e       nxt_state;
    logic [TIMER_W-1:0] timer;
    logic               reset_timer;
    logic               inc_timer;
    logic               reset_word;
    logic               inc_word;
    logic               rd_req;
    logic               wr_req;
    logic               mem_init;
    logic               debounce_hit;
    logic               timeout_hit;
    logic               last_word;

    assign debounce_hit = (timer == TIMER_W'(`PROXY_INIT_DEBOUNCE));
    assign timeout_hit  = (timer == TIMER_W'(`PROXY_TIMEOUT_CYCLES));
    assign last_word    = (word >= burst_len - burst_len_t'(1));

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) begin
            state <= ST_RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state     = state;
        accept        = 1'b0;
        init_done     = 1'b1;
        mem_init      = 1'b0;
        rd_req        = 1'b0;
        wr_req        = 1'b0;
        reset_timer   = 1'b0;
        inc_timer     = 1'b0;
        reset_word    = 1'b0;
        inc_word      = 1'b0;
        done_pulse    = 1'b0;
        error_pulse   = 1'b0;
        timeout_pulse = 1'b0;
        case (state)
            ST_RESET: begin
                init_done   = 1'b0;
                mem_init    = 1'b1;
                reset_timer = 1'b1;
                nxt_state   = ST_INIT_DEBOUNCE;
            end
            ST_INIT_DEBOUNCE: begin
                init_done = 1'b0;
                inc_timer = 1'b1;
                if (debounce_hit) begin
                    nxt_state = ST_INIT_PENDING;
                end
            end
            ST_INIT_PENDING: begin
                init_done = 1'b0;
                if (mem_rsp.rdy) begin
                    nxt_state = ST_IDLE;
                end
            end
            ST_IDLE: begin
                accept      = 1'b1;
                reset_timer = 1'b1;
                reset_word  = 1'b1;
                if (req) begin
                    case (cur_cmd.code)
                        CMD_READ:  nxt_state = ST_READ_REQ;
                        CMD_WRITE: nxt_state = ST_WRITE_REQ;
                        CMD_CLEAR: nxt_state = ST_CLEAR_REQ;
                        default:   nxt_state = ST_DONE;
                    endcase
                end
            end
            ST_READ_REQ: begin
                inc_timer = 1'b1;
                rd_req    = 1'b1;
                if (mem_rsp.rdy) begin
                    nxt_state = ST_READ_PENDING;
                end
            end
            ST_READ_PENDING: begin
                inc_timer = 1'b1;
                if (mem_rsp.rd_ack) begin
                    inc_word  = 1'b1;
                    nxt_state = last_word ? ST_DONE : ST_READ_REQ;
                end else if (timeout_hit) begin
                    nxt_state = ST_TIMEOUT;
                end
            end
            ST_WRITE_REQ: begin
                inc_timer = 1'b1;
                wr_req    = 1'b1;
                if (mem_rsp.rdy) begin
                    nxt_state = ST_WRITE_PENDING;
                end
            end
            ST_WRITE_PENDING: begin
                inc_timer = 1'b1;
                if (mem_rsp.wr_ack) begin
                    inc_word  = 1'b1;
                    nxt_state = last_word ? ST_DONE : ST_WRITE_REQ;
                end else if (timeout_hit) begin
                    nxt_state = ST_TIMEOUT;
                end
            end
            // Clear repeats the init sequence with the timer already at zero
            ST_CLEAR_REQ: begin
                inc_timer = 1'b1;
                mem_init  = 1'b1;
                nxt_state = ST_CLEAR_DEBOUNCE;
            end
            ST_CLEAR_DEBOUNCE: begin
                inc_timer = 1'b1;
                if (debounce_hit) begin
                    nxt_state = ST_CLEAR_PENDING;
                end
            end
            ST_CLEAR_PENDING: begin
                if (mem_rsp.rdy) begin
                    nxt_state = ST_DONE;
                end
            end
            ST_DONE: begin
                done_pulse = 1'b1;
                nxt_state  = ST_IDLE;
            end
            ST_TIMEOUT: begin
                timeout_pulse = 1'b1;
                nxt_state     = ST_IDLE;
            end
            default: begin
                error_pulse = 1'b1;
                nxt_state   = ST_IDLE;
            end
        endcase
    end

    // ------------------------------
    // Timer and burst word count
    // ------------------------------
    always_ff @(posedge clk) begin
        if (local_srst || reset_timer) begin
            timer <= '0;
        end else if (inc_timer) begin
            timer <= timer + TIMER_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (local_srst || reset_word) begin
            word <= '0;
        end else if (inc_word) begin
            word <= word + burst_len_t'(1);
        end
    end

    // Memory port, one word per request
    assign mem_req.init    = mem_init;
    assign mem_req.req     = rd_req || wr_req;
    assign mem_req.wr      = wr_req;
    assign mem_req.addr    = cur_cmd.addr + `PROXY_ADDR_W'(word);
    assign mem_req.wr_data = cur_cmd.wr_data[word[IDX_W-1:0]];

endmodule : proxy_fsm

`default_nettype wire

// ==== proxy_pkg.sv ====
`default_nettype none
`include "proxy_cfg.svh"

package proxy_pkg;

    // ------------------------------
    // Codes and states
    // ------------------------------
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_CLEAR = 2'd3
    } cmd_code_e;

    typedef enum logic [3:0] {
        ST_RESET          = 4'd0,
        ST_INIT_DEBOUNCE  = 4'd1,
        ST_INIT_PENDING   = 4'd2,
        ST_IDLE           = 4'd3,
        ST_READ_REQ       = 4'd4,
        ST_READ_PENDING   = 4'd5,
        ST_WRITE_REQ      = 4'd6,
        ST_WRITE_PENDING  = 4'd7,
        ST_CLEAR_REQ      = 4'd8,
        ST_CLEAR_DEBOUNCE = 4'd9,
        ST_CLEAR_PENDING  = 4'd10,
        ST_DONE           = 4'd11,
        ST_TIMEOUT        = 4'd12
    } proxy_state_e;

    typedef enum logic [1:0] {
        STATUS_RESET = 2'd0,
        STATUS_READY = 2'd1,
        STATUS_BUSY  = 2'd2
    } status_code_e;

    // ------------------------------
    // Payloads
    // ------------------------------
    // Word count of a burst, also used as the word index
    typedef logic [$clog2(`PROXY_BURST_MAX+1)-1:0] burst_len_t;

    // Burst size in bytes
    typedef logic [$clog2(`PROXY_BURST_MAX*`PROXY_DATA_BYTES+1)-1:0] burst_size_t;

    typedef logic [`PROXY_BURST_MAX-1:0][`PROXY_DATA_W-1:0] burst_data_t;

    typedef struct packed {
        cmd_code_e               code;
        logic [`PROXY_ADDR_W-1:0] addr;
        burst_len_t              len;
        burst_data_t             wr_data;
    } proxy_cmd_t;

    typedef struct packed {
        logic                     init;
        logic                     req;
        logic                     wr;
        logic [`PROXY_ADDR_W-1:0] addr;
        logic [`PROXY_DATA_W-1:0] wr_data;
    } mem_req_t;

    typedef struct packed {
        logic                     rdy;
        logic                     wr_ack;
        logic                     rd_ack;
        logic [`PROXY_DATA_W-1:0] rd_data;
    } mem_rsp_t;

    typedef struct packed {
        status_code_e code;
        logic         done;
        logic         error;
        logic         timeout;
        burst_size_t  burst_size;
    } proxy_status_t;

endpackage : proxy_pkg

`default_nettype wire

// ==== proxy_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module proxy_top (
    input  logic                     clk,
    input  logic                     local_srst,
    input  logic                     cmd_valid,
    input  proxy_pkg::proxy_cmd_t    cmd,
    input  logic                     status_rd,
    input  proxy_pkg::mem_rsp_t      mem_rsp,
    output logic                     init_done,
    output proxy_pkg::mem_req_t      mem_req,
    output proxy_pkg::proxy_status_t status,
    output proxy_pkg::burst_data_t   rd_data
);
    import proxy_pkg::*;

    // ------------------------------
    // Internal connections
    // ------------------------------
    logic         req;
    logic         accept;
    proxy_cmd_t   cur_cmd;
    burst_len_t   burst_len;
    proxy_state_e state;
    burst_len_t   word;
    logic         done_pulse;
    logic         error_pulse;
    logic         timeout_pulse;

    cmd_latch i_cmd_latch (
        .clk        (clk),
        .local_srst (local_srst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .accept     (accept),
        .req        (req),
        .cur_cmd    (cur_cmd),
        .burst_len  (burst_len)
    );

    proxy_fsm i_proxy_fsm (
        .clk           (clk),
        .local_srst    (local_srst),
        .req           (req),
        .cur_cmd       (cur_cmd),
        .burst_len     (burst_len),
        .mem_rsp       (mem_rsp),
        .accept        (accept),
        .init_done     (init_done),
        .mem_req       (mem_req),
        .state         (state),
        .word          (word),
        .done_pulse    (done_pulse),
        .error_pulse   (error_pulse),
        .timeout_pulse (timeout_pulse)
    );

    result_regs i_result_regs (
        .clk           (clk),
        .local_srst    (local_srst),
        .state         (state),
        .word          (word),
        .mem_rsp       (mem_rsp),
        .req           (req),
        .burst_len     (burst_len),
        .done_pulse    (done_pulse),
        .error_pulse   (error_pulse),
        .timeout_pulse (timeout_pulse),
        .status_rd     (status_rd),
        .status        (status),
        .rd_data       (rd_data)
    );

endmodule : proxy_top

`default_nettype wire

// ==== result_regs.sv ====
`timescale 1ns/1ps
`include "proxy_cfg.svh"
`default_nettype none

module result_regs (
    input  logic                     clk,
    input  logic                     local_srst,
    input  proxy_pkg::proxy_state_e  state,
    input  proxy_pkg::burst_len_t    word,
    input  proxy_pkg::mem_rsp_t      mem_rsp,
    input  logic                     req,
    input  proxy_pkg::burst_len_t    burst_len,
    input  logic                     done_pulse,
    input  logic                     error_pulse,
    input  logic                     timeout_pulse,
    input  logic                     status_rd,
    output proxy_pkg::proxy_status_t status,
    output proxy_pkg::burst_data_t   rd_data
);
    import proxy_pkg::*;

    localparam int IDX_W = $clog2(`PROXY_BURST_MAX);

    status_code_e status_code;
    logic         status_done;
    logic         status_error;
    logic         status_timeout;
    burst_size_t  status_burst_size;
    logic         clear_flags;

    // A new command or a status read drops the sticky flags
    assign clear_flags = req || status_rd;

    // Read words land at the index of the word being acknowledged
    always_ff @(posedge clk) begin
        if (mem_rsp.rd_ack) begin
            rd_data[word[IDX_W-1:0]] <= mem_rsp.rd_data;
        end
    end

    // ------------------------------
    // Status
    // ------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) begin
            status_code       <= STATUS_RESET;
            status_done       <= 1'b0;
            status_error      <= 1'b0;
            status_timeout    <= 1'b0;
            status_burst_size <= '0;
        end else begin
            // Reset code holds through the whole init sequence
            case (state)
                ST_RESET,
                ST_INIT_DEBOUNCE,
                ST_INIT_PENDING: status_code <= STATUS_RESET;
                ST_IDLE:         status_code <= STATUS_READY;
                default:         status_code <= STATUS_BUSY;
            endcase
            if (done_pulse) begin
                status_done <= 1'b1;
            end else if (clear_flags) begin
                status_done <= 1'b0;
            end
            if (error_pulse) begin
                status_error <= 1'b1;
            end else if (clear_flags) begin
                status_error <= 1'b0;
            end
            if (timeout_pulse) begin
                status_timeout <= 1'b1;
            end else if (clear_flags) begin
                status_timeout <= 1'b0;
            end
            // Size in bytes of the burst that completed
            if (timeout_pulse) begin
                status_burst_size <= '0;
            end else if (done_pulse) begin
                status_burst_size <= burst_size_t'(burst_len) *
                                     burst_size_t'(`PROXY_DATA_BYTES);
            end else if (req) begin
                status_burst_size <= '0;
            end
        end
    end

    assign status = '{
        code:       status_code,
        done:       status_done,
        error:      status_error,
        timeout:    status_timeout,
        burst_size: status_burst_size
    };

endmodule : result_regs

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_proxy \
        -f flist.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/Vtb_proxy); then
    echo "$output"
    echo "Simulation exited with an error"
    exit 1
fi
echo "$output"

if echo "$output" | grep -q "^Everything OK$"; then
    exit 0
fi
exit 1

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`include "proxy_cfg.svh"
`default_nettype none

module tb_checker (
    input  logic                        clk,
    input  logic                        check,
    input  logic                        row_end,
    input  logic                        report,
    input  logic [7:0]                  row_num,
    input  proxy_pkg::proxy_status_t    exp_status,
    input  proxy_pkg::burst_data_t      exp_rd,
    input  logic [`PROXY_BURST_MAX-1:0] rd_mask,
    input  proxy_pkg::proxy_status_t    status,
    input  proxy_pkg::burst_data_t      rd_data,
    input  logic                        init_done,
    input  logic                        mem_init,
    output int                          errors
);
    import proxy_pkg::*;

    int   mismatches  = 0;
    int   row_errs    = 0;
    int   rows_done   = 0;
    int   rows_failed = 0;
    int   init_age    = 0;
    logic init_seen   = 1'b0;
    logic init_done_q = 1'b0;

    assign errors = mismatches;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] row %0d %s: got 0x%0h, expected 0x%0h", row_num, name, got, exp);
            mismatches++;
            row_errs++;
        end
    endtask

    // ------------------------------
    // Init debounce
    // ------------------------------
    // Cycles from the last init pulse to the rise of init_done
    always @(posedge clk) begin
        if (mem_init) begin
            init_age  = 0;
            init_seen = 1'b1;
        end else begin
            init_age++;
        end
        if (init_seen && init_done && !init_done_q &&
                init_age < `PROXY_INIT_DEBOUNCE + 1) begin
            $display("init_done rose %0d cycles after the init pulse, expected at least %0d",
                     init_age, `PROXY_INIT_DEBOUNCE + 1);
            mismatches++;
        end
        init_done_q = init_done;
    end

    // ------------------------------
    // Sampled on the edge after the request
    // ------------------------------
    always @(posedge clk) begin
        if (check) begin
            compare_field("status.code", 32'(status.code), 32'(exp_status.code));
            compare_field("status.done", 32'(status.done), 32'(exp_status.done));
            compare_field("status.error", 32'(status.error), 32'(exp_status.error));
            compare_field("status.timeout", 32'(status.timeout), 32'(exp_status.timeout));
            compare_field("status.burst_size", 32'(status.burst_size),
                          32'(exp_status.burst_size));
            for (int i = 0; i < `PROXY_BURST_MAX; i++) begin
                if (rd_mask[i]) begin
                    compare_field($sformatf("rd_data[%0d]", i), rd_data[i], exp_rd[i]);
                end
            end
        end
        if (row_end) begin
            if (row_errs == 0) begin
                $display("row %0d passed", row_num);
            end else begin
                $display("row %0d failed with %0d mismatches", row_num, row_errs);
                rows_failed++;
            end
            rows_done++;
            row_errs = 0;
        end
        if (report) begin
            $display("Checked %0d rows, %0d failed, %0d mismatches", rows_done, rows_failed,
                     mismatches);
        end
    end

endmodule : tb_checker

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic local_srst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

    // Reset drops shortly after the last reset edge
    initial begin
        local_srst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        local_srst = 1'b0;
    end

endmodule : tb_clk_gen

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps
`include "proxy_cfg.svh"
`default_nettype none

module tb_mem_model (
    input  logic                clk,
    input  logic                local_srst,
    input  proxy_pkg::mem_req_t mem_req,
    output proxy_pkg::mem_rsp_t mem_rsp
);
    import proxy_pkg::*;

    localparam int DEPTH = 64;
    localparam int IDX_W = $clog2(DEPTH);

    // Busy cycles after each init, longer than the debounce
    localparam int BUSY_CYCLES = 12;

    // Requests from here upward are taken but never acknowledged
    localparam logic [`PROXY_ADDR_W-1:0] DEAD_BASE = 16'h0030;

    logic [`PROXY_DATA_W-1:0] mem [DEPTH];
    logic [`PROXY_DATA_W-1:0] rd_word;
    logic                     ack_rd;
    logic                     ack_wr;
    logic [4:0]               busy_cnt;

    always @(posedge clk) begin
        if (local_srst) begin
            ack_rd   <= 1'b0;
            ack_wr   <= 1'b0;
            rd_word  <= '0;
            busy_cnt <= '0;
        end else begin
            ack_rd <= 1'b0;
            ack_wr <= 1'b0;
            if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 5'd1;
            end
            if (mem_req.init) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[i] <= '0;
                end
                busy_cnt <= 5'(BUSY_CYCLES);
            end else if (mem_req.req && mem_rsp.rdy && mem_req.addr < DEAD_BASE) begin
                // Acknowledge lands one cycle after the accepted request
                if (mem_req.wr) begin
                    mem[mem_req.addr[IDX_W-1:0]] <= mem_req.wr_data;
                    ack_wr <= 1'b1;
                end else begin
                    rd_word <= mem[mem_req.addr[IDX_W-1:0]];
                    ack_rd  <= 1'b1;
                end
            end
        end
    end

    // Not ready while busy after init
    assign mem_rsp = '{rdy: (busy_cnt == '0), wr_ack: ack_wr, rd_ack: ack_rd, rd_data: rd_word};

endmodule : tb_mem_model

`default_nettype wire

// ==== tb_proxy.sv ====
`timescale 1ns/1ps
`include "proxy_cfg.svh"
`default_nettype none

module tb_proxy;
    import proxy_pkg::*;

    localparam int NUM_ROWS   = 9;
    localparam int MAX_CYCLES = NUM_ROWS * (`PROXY_TIMEOUT_CYCLES + 20) + 100;

    typedef struct packed {
        cmd_code_e                   code;
        logic [`PROXY_ADDR_W-1:0]    addr;
        burst_len_t                  len;
        burst_data_t                 wr_data;
        logic                        exp_done;
        logic                        exp_timeout;
        burst_size_t                 exp_size;
        burst_data_t                 exp_rd;
        logic [`PROXY_BURST_MAX-1:0] rd_mask;
    } row_t;

    logic                        clk;
    logic                        local_srst;
    logic                        cmd_valid;
    proxy_cmd_t                  cmd;
    logic                        status_rd;
    mem_rsp_t                    mem_rsp;
    logic                        init_done;
    mem_req_t                    mem_req;
    proxy_status_t               status;
    burst_data_t                 rd_data;
    logic                        check;
    logic                        row_end;
    logic                        report;
    logic [7:0]                  row_num;
    proxy_status_t               exp_status;
    burst_data_t                 exp_rd;
    logic [`PROXY_BURST_MAX-1:0] rd_mask;
    int                          errors;
    int                          cycles = 0;
    integer                      seed;
    row_t                        rows [NUM_ROWS];

    tb_clk_gen i_clk_gen (
        .clk        (clk),
        .local_srst (local_srst)
    );

    proxy_top i_proxy_top (
        .clk        (clk),
        .local_srst (local_srst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .status_rd  (status_rd),
        .mem_rsp    (mem_rsp),
        .init_done  (init_done),
        .mem_req    (mem_req),
        .status     (status),
        .rd_data    (rd_data)
    );

    tb_mem_model i_mem_model (
        .clk        (clk),
        .local_srst (local_srst),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    tb_checker i_checker (
        .clk        (clk),
        .check      (check),
        .row_end    (row_end),
        .report     (report),
        .row_num    (row_num),
        .exp_status (exp_status),
        .exp_rd     (exp_rd),
        .rd_mask    (rd_mask),
        .status     (status),
        .rd_data    (rd_data),
        .init_done  (init_done),
        .mem_init   (mem_req.init),
        .errors     (errors)
    );

    // ------------------------------
    // Stimulus table
    // ------------------------------
    task automatic build_table();
        burst_data_t wr_a;
        burst_data_t wr_b;
        burst_data_t rd_one;
        burst_data_t zero;
        zero = '0;
        for (int i = 0; i < `PROXY_BURST_MAX; i++) begin
            wr_a[i] = $random(seed);
        end
        wr_b    = '0;
        wr_b[0] = $random(seed);
        wr_b[1] = $random(seed);
        // Single word read from the middle of the first burst
        rd_one    = '0;
        rd_one[0] = wr_a[2];
        rows[0] = '{CMD_WRITE, 16'h0010, 3'd4, wr_a, 1'b1, 1'b0, 5'd16, wr_a, 4'b0000};
        rows[1] = '{CMD_READ,  16'h0010, 3'd4, zero, 1'b1, 1'b0, 5'd16, wr_a, 4'b1111};
        rows[2] = '{CMD_READ,  16'h0012, 3'd0, zero, 1'b1, 1'b0, 5'd4, rd_one, 4'b0001};
        rows[3] = '{CMD_CLEAR, 16'h0000, 3'd0, zero, 1'b1, 1'b0, 5'd4, zero, 4'b0000};
        rows[4] = '{CMD_READ,  16'h0010, 3'd4, zero, 1'b1, 1'b0, 5'd16, zero, 4'b1111};
        rows[5] = '{CMD_WRITE, 16'h0020, 3'd2, wr_b, 1'b1, 1'b0, 5'd8, wr_b, 4'b0000};
        rows[6] = '{CMD_READ,  16'h0020, 3'd3, zero, 1'b1, 1'b0, 5'd12, wr_b, 4'b0111};
        rows[7] = '{CMD_READ,  16'h0030, 3'd1, zero, 1'b0, 1'b1, 5'd0, zero, 4'b0000};
        rows[8] = '{CMD_NOP,   16'h0000, 3'd0, zero, 1'b1, 1'b0, 5'd4, zero, 4'b0000};
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // One checker sample, optionally closing the row
    task automatic request_check(input logic last);
        check   = 1'b1;
        row_end = last;
        next_cycle();
        check   = 1'b0;
        row_end = 1'b0;
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        r         = rows[idx];
        row_num   = 8'(idx + 1);
        cmd       = '{r.code, r.addr, r.len, r.wr_data};
        cmd_valid = 1'b1;
        next_cycle();
        cmd_valid = 1'b0;
        while (!(status.done || status.timeout || status.error)) begin
            next_cycle();
        end
        // Status code follows the return to idle one cycle later
        next_cycle();
        exp_status = '{STATUS_READY, r.exp_done, 1'b0, r.exp_timeout, r.exp_size};
        exp_rd     = r.exp_rd;
        rd_mask    = r.rd_mask;
        request_check(1'b0);
        status_rd = 1'b1;
        next_cycle();
        status_rd = 1'b0;
        // Flags gone, burst size kept
        exp_status = '{STATUS_READY, 1'b0, 1'b0, 1'b0, r.exp_size};
        request_check(1'b1);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        seed       = 32'h7336_2d76;
        cmd_valid  = 1'b0;
        cmd        = '0;
        status_rd  = 1'b0;
        check      = 1'b0;
        row_end    = 1'b0;
        report     = 1'b0;
        row_num    = '0;
        exp_status = '0;
        exp_rd     = '0;
        rd_mask    = '0;
        build_table();

        do begin
            @(posedge clk);
        end while (local_srst);
        #1;
        // Status stays in reset until the first idle
        exp_status = '{STATUS_RESET, 1'b0, 1'b0, 1'b0, 5'd0};
        while (!init_done) begin
            request_check(1'b0);
        end
        next_cycle();
        exp_status = '{STATUS_READY, 1'b0, 1'b0, 1'b0, 5'd0};
        request_check(1'b1);

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end

        report = 1'b1;
        next_cycle();
        report = 1'b0;
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Run limit covers the worst case of every row timing out
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: no completion within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

endmodule : tb_proxy

`default_nettype wire
